// ==== all.f ====
+incdir+test
source/tcp_net_pkg.sv
source/tcp_hdr_pkg.sv
source/tcp_rx_cfg.sv
source/tcp_hdr_parse.sv
source/tcp_opt_parse.sv
source/tcp_rx_top.sv
test/tcp_rx_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tcp_rx_tb
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SRCS := $(wildcard source/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^Simulation PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/tcp_rx_tb_frames.svh ====
`ifndef TCP_RX_TB_FRAMES_SVH
`define TCP_RX_TB_FRAMES_SVH

// columns: fixed header, option bytes (first byte in the msbs), payload byte count,
// ip metadata, config write valid, config write, hdr_v expected, err expected,
// expected decoded options
typedef struct packed {
  tcp_hdr_pkg::tcp_hdr_t hdr;
  logic [319:0]          opts;
  logic [15:0]           pay_n;
  tcp_net_pkg::ip_meta_t meta;
  logic                  cfg_v;
  tcp_net_pkg::cfg_wr_t  cfg;
  logic                  exp_hdr;
  logic                  exp_err;
  tcp_hdr_pkg::tcp_opt_t exp_opt;
} frame_t;

localparam int          N_FRAMES = 8;
localparam logic [15:0] DEF_PORT = 16'd80;
localparam logic [15:0] ALT_PORT = 16'h1f90;

localparam frame_t FRAMES [N_FRAMES] = '{
  // bare header with payload
  '{{16'h1234, DEF_PORT, 32'h11223344, 32'h55667788,
     4'd5, 3'd0, 9'h018, 16'hffff, 16'habcd, 16'h0000},
    '0, 16'd8, '{8'd6, 16'd28, 32'hc0a80001}, 1'b0, '0, 1'b1, 1'b0, '0},
  // mss, nop, window scale, sack permitted, timestamp
  '{{16'h4000, DEF_PORT, 32'h00000100, 32'h00000000,
     4'd10, 3'd0, 9'h002, 16'h7210, 16'h1111, 16'h0000},
    {8'h02, 8'h04, 8'h05, 8'hb4, 8'h01, 8'h03, 8'h03, 8'h07, 8'h04, 8'h02,
     8'h08, 8'h0a, 32'hdeadbeef, 32'h01020304, 160'd0},
    16'd4, '{8'd6, 16'd44, 32'hc0a80002}, 1'b0, '0, 1'b1, 1'b0,
    {1'b1, 16'h05b4, 1'b1, 8'h07, 1'b1, 1'b0, 1'b1, 32'hdeadbeef, 32'h01020304}},
  // sack block then END, the mss after END must be ignored, no payload
  '{{16'h4001, DEF_PORT, 32'h00000200, 32'h00000010,
     4'd9, 3'd0, 9'h010, 16'h0400, 16'h2222, 16'h0000},
    {8'h01, 8'h01, 8'h05, 8'h0a, 32'h00001000, 32'h00002000,
     8'h00, 8'h02, 8'h04, 8'h05, 192'd0},
    16'd0, '{8'd6, 16'd36, 32'hc0a80003}, 1'b0, '0, 1'b1, 1'b0,
    {1'b0, 16'h0000, 1'b0, 8'h00, 1'b0, 1'b1, 1'b0, 32'h0, 32'h0}},
  // wrong destination port
  '{{16'h5555, ALT_PORT, 32'h00000300, 32'h00000020,
     4'd5, 3'd0, 9'h018, 16'h1000, 16'h3333, 16'h0000},
    '0, 16'd5, '{8'd6, 16'd25, 32'hc0a80004}, 1'b0, '0, 1'b0, 1'b0, '0},
  // udp protocol byte
  '{{16'h6666, DEF_PORT, 32'h00000400, 32'h00000030,
     4'd5, 3'd0, 9'h018, 16'h1000, 16'h4444, 16'h0000},
    '0, 16'd3, '{8'd17, 16'd23, 32'hc0a80005}, 1'b0, '0, 1'b0, 1'b0, '0},
  // frame shorter than the ip payload length
  '{{16'h7777, DEF_PORT, 32'h00000500, 32'h00000040,
     4'd5, 3'd0, 9'h019, 16'h2000, 16'h5555, 16'h0000},
    '0, 16'd6, '{8'd6, 16'd40, 32'hc0a80006}, 1'b0, '0, 1'b1, 1'b1, '0},
  // move the local port, the earlier rejected port now passes
  '{{16'h8888, ALT_PORT, 32'h00000600, 32'h00000050,
     4'd5, 3'd0, 9'h018, 16'h3000, 16'h6666, 16'h0000},
    '0, 16'd3, '{8'd6, 16'd23, 32'hc0a80007}, 1'b1,
    '{tcp_net_pkg::CFG_SEL_PORT, ALT_PORT}, 1'b1, 1'b0, '0},
  // receive disabled
  '{{16'h9999, ALT_PORT, 32'h00000700, 32'h00000060,
     4'd5, 3'd0, 9'h018, 16'h4000, 16'h7777, 16'h0000},
    '0, 16'd3, '{8'd6, 16'd23, 32'hc0a80008}, 1'b1,
    '{tcp_net_pkg::CFG_SEL_EN, 16'h0000}, 1'b0, 1'b0, '0}
};

`endif

// ==== test/tcp_rx_tb.sv ====
`timescale 1ns/1ps

module tcp_rx_tb;

  `include "tcp_rx_tb_frames.svh"

  logic                  clk = 1'b0;
  logic                  fsm_rst;
  logic                  rx_v;
  logic                  rx_sof;
  logic                  rx_eof;
  logic [7:0]            rx_d;
  tcp_net_pkg::ip_meta_t rx_meta;
  logic                  cfg_wr_v;
  tcp_net_pkg::cfg_wr_t  cfg_wr;
  logic                  hdr_v;
  tcp_hdr_pkg::tcp_hdr_t hdr;
  tcp_hdr_pkg::tcp_opt_t opt;
  logic                  pay_v;
  logic                  pay_sof;
  logic                  pay_eof;
  logic [7:0]            pay_d;
  logic                  err;

  int cur = 0;
  int pay_base = 0;
  int hdr_cnt = 0;
  int pay_cnt = 0;
  int err_cnt = 0;
  int cycles = 0;
  int cycle_limit;

  always #2 clk = ~clk;

  tcp_rx_top #(
    .DEF_PORT (DEF_PORT)
  ) i_dut (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .rx_v     (rx_v),
    .rx_sof   (rx_sof),
    .rx_eof   (rx_eof),
    .rx_d     (rx_d),
    .rx_meta  (rx_meta),
    .cfg_wr_v (cfg_wr_v),
    .cfg_wr   (cfg_wr),
    .hdr_v    (hdr_v),
    .hdr      (hdr),
    .opt      (opt),
    .pay_v    (pay_v),
    .pay_sof  (pay_sof),
    .pay_eof  (pay_eof),
    .pay_d    (pay_d),
    .err      (err)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [159:0] got,
                             input logic [159:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h in frame %0d",
                          name, got, exp, cur));
    end
  endtask

  // payload pattern, different in every frame
  function automatic logic [7:0] pay_byte(input int f, input int i);
    return 8'(f * 37 + i * 11 + 5);
  endfunction

  function automatic int frame_len(input int f);
    return int'(FRAMES[f].hdr.data_off) * 4 + int'(FRAMES[f].pay_n);
  endfunction

  // wire order: fixed header, options, payload
  function automatic logic [7:0] frame_byte(input int f, input int i);
    logic [159:0] h;
    logic [319:0] o;
    int           hlen;
    h    = FRAMES[f].hdr;
    o    = FRAMES[f].opts;
    hlen = int'(FRAMES[f].hdr.data_off) * 4;
    if (i < 20) begin
      return h[159 - 8 * i -: 8];
    end else if (i < hlen) begin
      return o[319 - 8 * (i - 20) -: 8];
    end
    return pay_byte(f, i - hlen);
  endfunction

  function automatic int run_limit();
    int f;
    int total;
    total = 20;
    for (f = 0; f < N_FRAMES; f++) begin
      // a byte takes up to three cycles with its gap
      total += 3 * frame_len(f) + 24;
    end
    return total;
  endfunction

  task automatic drive_byte(input logic [7:0] d, input logic sof, input logic eof,
                            input tcp_net_pkg::ip_meta_t m);
    int gap;
    gap     = int'($urandom % 3);
    rx_v    = 1'b1;
    rx_d    = d;
    rx_sof  = sof;
    rx_eof  = eof;
    rx_meta = sof ? m : '0;
    @(posedge clk);
    #1;
    rx_v    = 1'b0;
    rx_sof  = 1'b0;
    rx_eof  = 1'b0;
    rx_meta = '0;
    repeat (gap) begin
      @(posedge clk);
      #1;
    end
  endtask

  // outputs settle after the rising edge, look at them mid cycle
  always @(negedge clk) begin
    if (!fsm_rst) begin
      if (hdr_v) begin
        hdr_cnt = hdr_cnt + 1;
        check_value("hdr", 160'(hdr), 160'(FRAMES[cur].hdr));
        check_value("opt", 160'(opt), 160'(FRAMES[cur].exp_opt));
      end
      if (pay_v) begin
        check_value("pay_d", 160'(pay_d), 160'(pay_byte(cur, pay_cnt - pay_base)));
        check_value("pay_sof", 160'(pay_sof), 160'(pay_cnt == pay_base));
        check_value("pay_eof", 160'(pay_eof),
                    160'((pay_cnt - pay_base) == (int'(FRAMES[cur].pay_n) - 1)));
        pay_cnt = pay_cnt + 1;
      end
      if (err) begin
        err_cnt = err_cnt + 1;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      abort_run($sformatf("Timeout after %0d cycles, the frames did not finish", cycles));
    end
  end

  initial begin
    int f;
    int i;
    int n;
    int h0;
    int e0;
    void'($urandom(66102));
    cycle_limit = run_limit();
    fsm_rst     = 1'b1;
    rx_v        = 1'b0;
    rx_sof      = 1'b0;
    rx_eof      = 1'b0;
    rx_d        = 8'h00;
    rx_meta     = '0;
    cfg_wr_v    = 1'b0;
    cfg_wr      = '0;
    repeat (3) @(posedge clk);
    #1;
    fsm_rst = 1'b0;
    check_value("strobes after reset", 160'({hdr_v, pay_v, pay_sof, pay_eof, err}), 160'(0));
    for (f = 0; f < N_FRAMES; f++) begin
      cur      = f;
      pay_base = pay_cnt;
      h0       = hdr_cnt;
      e0       = err_cnt;
      if (FRAMES[f].cfg_v) begin
        cfg_wr_v = 1'b1;
        cfg_wr   = FRAMES[f].cfg;
        @(posedge clk);
        #1;
        cfg_wr_v = 1'b0;
      end
      n = frame_len(f);
      for (i = 0; i < n; i++) begin
        drive_byte(frame_byte(f, i), i == 0, i == n - 1, FRAMES[f].meta);
      end
      // payload trails its input byte by two cycles, err by one
      repeat (3) begin
        @(posedge clk);
        #1;
      end
      check_value("hdr_v count", 160'(hdr_cnt - h0), 160'(FRAMES[f].exp_hdr));
      check_value("pay_v count", 160'(pay_cnt - pay_base),
                  160'(FRAMES[f].exp_hdr ? FRAMES[f].pay_n : 16'd0));
      check_value("err count", 160'(err_cnt - e0), 160'(FRAMES[f].exp_err));
    end
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== source/tcp_rx_top.sv ====
`timescale 1ns/1ps

module tcp_rx_top #(
  parameter logic [15:0] DEF_PORT = 16'd80
) (
  input  logic                  clk,
  input  logic                  fsm_rst,
  input  logic                  rx_v,
  input  logic                  rx_sof,
  input  logic                  rx_eof,
  input  logic [7:0]            rx_d,
  input  tcp_net_pkg::ip_meta_t rx_meta,
  input  logic                  cfg_wr_v,
  input  tcp_net_pkg::cfg_wr_t  cfg_wr,
  output logic                  hdr_v,
  output tcp_hdr_pkg::tcp_hdr_t hdr,
  output tcp_hdr_pkg::tcp_opt_t opt,
  output logic                  pay_v,
  output logic                  pay_sof,
  output logic                  pay_eof,
  output logic [7:0]            pay_d,
  output logic                  err
);

  logic [15:0] local_port;
  logic        rx_en;
  logic        opt_v;
  logic        opt_start;
  logic [7:0]  opt_d;

  tcp_rx_cfg #(
    .DEF_PORT (DEF_PORT)
  ) i_cfg (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .cfg_wr_v   (cfg_wr_v),
    .cfg_wr     (cfg_wr),
    .local_port (local_port),
    .rx_en      (rx_en)
  );

  tcp_hdr_parse i_hdr (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .rx_v       (rx_v),
    .rx_sof     (rx_sof),
    .rx_eof     (rx_eof),
    .rx_d       (rx_d),
    .rx_meta    (rx_meta),
    .local_port (local_port),
    .rx_en      (rx_en),
    .opt_v      (opt_v),
    .opt_start  (opt_start),
    .opt_d      (opt_d),
    .hdr_v      (hdr_v),
    .hdr        (hdr),
    .pay_v      (pay_v),
    .pay_sof    (pay_sof),
    .pay_eof    (pay_eof),
    .pay_d      (pay_d),
    .err        (err)
  );

  tcp_opt_parse i_opt (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .opt_start (opt_start),
    .opt_v     (opt_v),
    .opt_d     (opt_d),
    .opt       (opt)
  );

endmodule

// ==== source/tcp_opt_parse.sv ====
`timescale 1ns/1ps

module tcp_opt_parse (
  input  logic                  clk,
  input  logic                  fsm_rst,
  input  logic                  opt_start,
  input  logic                  opt_v,
  input  logic [7:0]            opt_d,
  output tcp_hdr_pkg::tcp_opt_t opt
);

  // data offset tops out at 60 bytes
  localparam int OPT_AREA = 60 - tcp_hdr_pkg::MIN_HDR_LEN;
  // timestamp value and echo are the longest option value
  localparam int VAL_BYTES = 8;

  tcp_hdr_pkg::opt_state_t   state;
  logic [7:0]                kind;
  logic [7:0]                data_left;
  logic [5:0]                opt_cnt;
  logic [VAL_BYTES-1:0][7:0] val_sr;
  logic [VAL_BYTES-1:0][7:0] val_next;
  logic                      len_bad;
  logic                      val_last;

  assign val_next = {val_sr[VAL_BYTES-2:0], opt_d};

  // kind byte sat at opt_cnt-1
  // the option has to end inside the area
  assign len_bad = (opt_d < 8'd2) ||
                   (({3'd0, opt_cnt} + {1'b0, opt_d}) > 9'(OPT_AREA + 1));

  assign val_last = opt_v && (state == tcp_hdr_pkg::ST_DATA) && (data_left == 8'd0);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state   <= tcp_hdr_pkg::ST_IDLE;
      opt_cnt <= '0;
    end else if (opt_start) begin
      state   <= tcp_hdr_pkg::ST_KIND;
      opt_cnt <= '0;
    end else if (opt_v && (state != tcp_hdr_pkg::ST_IDLE)) begin
      opt_cnt <= opt_cnt + 6'd1;
      case (state)
        tcp_hdr_pkg::ST_KIND: begin
          case (opt_d)
            tcp_hdr_pkg::OPT_NOP: begin
              state <= tcp_hdr_pkg::ST_KIND;
            end
            tcp_hdr_pkg::OPT_MSS, tcp_hdr_pkg::OPT_WIN, tcp_hdr_pkg::OPT_SACK_PERM,
            tcp_hdr_pkg::OPT_SACK, tcp_hdr_pkg::OPT_TS: begin
              state <= tcp_hdr_pkg::ST_LEN;
            end
            // end of list or a kind we cannot walk past
            default: begin
              state <= tcp_hdr_pkg::ST_IDLE;
            end
          endcase
        end
        tcp_hdr_pkg::ST_LEN: begin
          if (len_bad) begin
            state <= tcp_hdr_pkg::ST_IDLE;
          end else if (opt_d == 8'd2) begin
            state <= tcp_hdr_pkg::ST_KIND;
          end else begin
            state <= tcp_hdr_pkg::ST_DATA;
          end
        end
        tcp_hdr_pkg::ST_DATA: begin
          if (data_left == 8'd0) begin
            state <= tcp_hdr_pkg::ST_KIND;
          end
        end
        default: begin
          state <= tcp_hdr_pkg::ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (opt_v) begin
      if (state == tcp_hdr_pkg::ST_KIND) begin
        kind <= opt_d;
      end
      // length counts the kind and length bytes
      // counter ends at zero
      if (state == tcp_hdr_pkg::ST_LEN) begin
        data_left <= opt_d - 8'd3;
      end
      if (state == tcp_hdr_pkg::ST_DATA) begin
        val_sr    <= val_next;
        data_left <= data_left - 8'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (opt_start) begin
      opt <= '0;
    end else if (opt_v && (state == tcp_hdr_pkg::ST_KIND)) begin
      // no value to wait for on these two
      if (opt_d == tcp_hdr_pkg::OPT_SACK_PERM) begin
        opt.sack_perm_pres <= 1'b1;
      end
      if (opt_d == tcp_hdr_pkg::OPT_SACK) begin
        opt.sack_pres <= 1'b1;
      end
    end else if (val_last) begin
      case (kind)
        tcp_hdr_pkg::OPT_MSS: begin
          opt.mss_pres <= 1'b1;
          opt.mss      <= {val_next[1], val_next[0]};
        end
        tcp_hdr_pkg::OPT_WIN: begin
          opt.win_pres  <= 1'b1;
          opt.win_shift <= val_next[0];
        end
        tcp_hdr_pkg::OPT_TS: begin
          opt.ts_pres <= 1'b1;
          opt.ts_val  <= {val_next[7], val_next[6], val_next[5], val_next[4]};
          opt.ts_ecr  <= {val_next[3], val_next[2], val_next[1], val_next[0]};
        end
        // sack block values are skipped
        default: begin
        end
      endcase
    end
  end

endmodule

// ==== source/tcp_hdr_parse.sv ====
`timescale 1ns/1ps

module tcp_hdr_parse (
  input  logic                  clk,
  input  logic                  fsm_rst,
  input  logic                  rx_v,
  input  logic                  rx_sof,
  input  logic                  rx_eof,
  input  logic [7:0]            rx_d,
  input  tcp_net_pkg::ip_meta_t rx_meta,
  input  logic [15:0]           local_port,
  input  logic                  rx_en,
  output logic                  opt_v,
  output logic                  opt_start,
  output logic [7:0]            opt_d,
  output logic                  hdr_v,
  output tcp_hdr_pkg::tcp_hdr_t hdr,
  output logic                  pay_v,
  output logic                  pay_sof,
  output logic                  pay_eof,
  output logic [7:0]            pay_d,
  output logic                  err
);

  localparam logic [15:0] FIX_LAST = 16'(tcp_hdr_pkg::MIN_HDR_LEN - 1);
  localparam logic [15:0] FIX_LEN  = 16'(tcp_hdr_pkg::MIN_HDR_LEN);
  // data offset nibble lives in byte 12
  localparam logic [15:0] OFF_BYTE = 16'd12;

  logic             in_frame;
  logic             frame_v;
  logic [15:0]      byte_cnt;
  logic [15:0]      idx;
  logic             tcp_q;
  logic             tcp_now;
  logic [15:0]      len_q;
  logic [15:0]      len_now;
  logic [15:0]      hdr_end;
  logic [18:0][7:0] hdr_sr;
  logic             pass_q;
  logic             pass_now;
  logic             hdr_last;
  logic             is_opt;
  logic             is_pay;
  logic             hdr_q1;
  logic             p1_v;
  logic             p1_sof;
  logic             p1_eof;
  logic [7:0]       d_q1;

  // bytes outside a frame are dropped
  assign frame_v = rx_v && (rx_sof || in_frame);
  assign idx     = rx_sof ? 16'd0 : byte_cnt;
  assign tcp_now = rx_sof ? (rx_meta.proto == tcp_net_pkg::IP_PROTO_TCP) : tcp_q;
  assign len_now = rx_sof ? rx_meta.pay_len : len_q;

  // dst port is bytes 2 and 3, already in the shift register at byte 19
  assign pass_now = (idx == FIX_LAST) ?
                    (tcp_now && rx_en && ({hdr_sr[16], hdr_sr[15]} == local_port)) :
                    pass_q;

  // hdr_end is at least 20, so these only fire once byte 12 was seen
  assign hdr_last = frame_v && pass_now && (idx == hdr_end - 16'd1);
  assign is_opt   = frame_v && (idx > FIX_LAST) && (idx < hdr_end);
  assign is_pay   = frame_v && pass_now && (idx >= hdr_end);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      in_frame  <= 1'b0;
      byte_cnt  <= '0;
      pass_q    <= 1'b0;
      hdr_q1    <= 1'b0;
      hdr_v     <= 1'b0;
      opt_start <= 1'b0;
      opt_v     <= 1'b0;
      p1_v      <= 1'b0;
      p1_sof    <= 1'b0;
      p1_eof    <= 1'b0;
      pay_v     <= 1'b0;
      pay_sof   <= 1'b0;
      pay_eof   <= 1'b0;
      err       <= 1'b0;
    end else begin
      if (frame_v) begin
        in_frame <= !rx_eof;
        byte_cnt <= idx + 16'd1;
        // forget the previous frame's port match
        pass_q   <= rx_sof ? 1'b0 : pass_now;
      end
      // extra stage gives the option parser its capture cycle
      hdr_q1    <= hdr_last;
      hdr_v     <= hdr_q1;
      opt_start <= frame_v && (idx == FIX_LAST);
      opt_v     <= is_opt;
      // payload runs two cycles behind the input
      p1_v      <= is_pay;
      p1_sof    <= is_pay && (idx == hdr_end);
      p1_eof    <= is_pay && rx_eof;
      pay_v     <= p1_v;
      pay_sof   <= p1_sof;
      pay_eof   <= p1_eof;
      // count at eof must equal the ip payload length
      err       <= frame_v && rx_eof && tcp_now && ((idx + 16'd1) != len_now);
    end
  end

  always_ff @(posedge clk) begin
    if (frame_v) begin
      if (rx_sof) begin
        tcp_q <= tcp_now;
        len_q <= len_now;
      end
      if (idx < FIX_LAST) begin
        hdr_sr <= {hdr_sr[17:0], rx_d};
      end
      // offsets below 5 words are bogus, treat as bare header
      if (idx == OFF_BYTE) begin
        hdr_end <= (rx_d[7:4] < 4'd5) ? FIX_LEN : {10'd0, rx_d[7:4], 2'b00};
      end
      if (rx_sof) begin
        hdr <= '0;
      end else if (idx == FIX_LAST) begin
        hdr <= tcp_hdr_pkg::tcp_hdr_t'({hdr_sr, rx_d});
      end
    end
    d_q1  <= rx_d;
    pay_d <= d_q1;
  end

  // option bytes share the first delay stage with the payload
  assign opt_d = d_q1;

endmodule

// ==== source/tcp_rx_cfg.sv ====
`timescale 1ns/1ps

module tcp_rx_cfg #(
  parameter logic [15:0] DEF_PORT = 16'd80
) (
  input  logic                 clk,
  input  logic                 fsm_rst,
  input  logic                 cfg_wr_v,
  input  tcp_net_pkg::cfg_wr_t cfg_wr,
  output logic [15:0]          local_port,
  output logic                 rx_en
);

  // receive side comes up listening on the default port
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      local_port <= DEF_PORT;
      rx_en      <= 1'b1;
    end else if (cfg_wr_v) begin
      case (cfg_wr.sel)
        tcp_net_pkg::CFG_SEL_PORT: begin
          local_port <= cfg_wr.data;
        end
        tcp_net_pkg::CFG_SEL_EN: begin
          rx_en <= cfg_wr.data[0];
        end
      endcase
    end
  end

endmodule

// ==== source/tcp_hdr_pkg.sv ====
package tcp_hdr_pkg;

  // fixed part of the tcp header in bytes
  localparam int MIN_HDR_LEN = 20;

  // option kinds
  localparam logic [7:0] OPT_END       = 8'd0;
  localparam logic [7:0] OPT_NOP       = 8'd1;
  localparam logic [7:0] OPT_MSS       = 8'd2;
  localparam logic [7:0] OPT_WIN       = 8'd3;
  localparam logic [7:0] OPT_SACK_PERM = 8'd4;
  localparam logic [7:0] OPT_SACK      = 8'd5;
  localparam logic [7:0] OPT_TS        = 8'd8;

  // field order matches the wire, first byte in the msbs
  typedef struct packed {
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [31:0] seq_num;
    logic [31:0] ack_num;
    // header length in 32-bit words
    logic [3:0]  data_off;
    logic [2:0]  rsvd;
    // ns cwr ece urg ack psh rst syn fin
    logic [8:0]  flags;
    logic [15:0] window;
    logic [15:0] checksum;
    logic [15:0] urg_ptr;
  } tcp_hdr_t;

  // decoded options of one header
  typedef struct packed {
    logic        mss_pres;
    logic [15:0] mss;
    logic        win_pres;
    logic [7:0]  win_shift;
    logic        sack_perm_pres;
    // sack blocks themselves are skipped
    logic        sack_pres;
    logic        ts_pres;
    logic [31:0] ts_val;
    logic [31:0] ts_ecr;
  } tcp_opt_t;

  // option walk: kind byte, length byte, value bytes
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_KIND = 2'd1,
    ST_LEN  = 2'd2,
    ST_DATA = 2'd3
  } opt_state_t;

endpackage

// ==== source/tcp_net_pkg.sv ====
package tcp_net_pkg;

  // protocol number of tcp in the ipv4 header
  localparam logic [7:0] IP_PROTO_TCP = 8'd6;

  // metadata handed over by the ip receiver
  // valid only in the rx_sof cycle
  typedef struct packed {
    logic [7:0]  proto;
    // tcp header plus payload, in bytes
    logic [15:0] pay_len;
    logic [31:0] src_addr;
  } ip_meta_t;

  // which configuration register a write goes to
  typedef enum logic {
    CFG_SEL_PORT = 1'b0,
    CFG_SEL_EN   = 1'b1
  } cfg_sel_t;

  // configuration write, qualified by cfg_wr_v
  typedef struct packed {
    cfg_sel_t    sel;
    // enable write uses bit 0 only
    logic [15:0] data;
  } cfg_wr_t;

endpackage
